//--- src/heap_defines.svh
// Heap size macros
// Array count, array length and element width for the fixed-size array heap

`ifndef HEAP_DEFINES_SVH
`define HEAP_DEFINES_SVH

// ------------------------------------------------------------
// Base widths
// ------------------------------------------------------------
`define HEAP_ARRAY_BITS 3                           // Bits in an array number
`define HEAP_INDEX_BITS 3                           // Bits in an element index
`define HEAP_DATA_BITS  16                          // Element width

// ------------------------------------------------------------
// Derived counts
// ------------------------------------------------------------
`define HEAP_ARRAYS       (1 << `HEAP_ARRAY_BITS)   // Arrays in the heap
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)   // Elements per array

`endif

//--- src/heapPkg.sv
// Heap package
// Opcode and error encodings plus the width-derived data types

`include "heap_defines.svh"

package heapPkg;

  // ------------------------------------------------------------
  // Request opcodes
  // ------------------------------------------------------------
  typedef enum logic [4:0] {
    opWrite    = 5'd2,                              // Write an element
    opRead     = 5'd3,                              // Read an element
    opSize     = 5'd4,                              // Current array size
    opPush     = 5'd14,                             // Append at the top
    opPop      = 5'd15,                             // Remove from the top
    opAlloc    = 5'd18,                             // Hand out an array
    opFree     = 5'd19,                             // Return an array
    opAdd      = 5'd20,                             // Add, new value back
    opAddAfter = 5'd21,                             // Add, old value back
    opSub      = 5'd22,                             // Subtract, new value back
    opSubAfter = 5'd23,                             // Subtract, old value back
    opNot      = 5'd27,                             // Bitwise invert
    opOr       = 5'd28,
    opXor      = 5'd29,
    opAnd      = 5'd30
  } opcodeT;

  // ------------------------------------------------------------
  // Response error codes
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                         // Never handed out
    errFreed        = 3'd2,                         // Handed out, then freed
    errOutOfBounds  = 3'd3,                         // Index at or past size
    errFull         = 3'd4,                         // Push onto full array
    errEmpty        = 3'd5,                         // Pop from empty array
    errNoMemory     = 3'd6                          // No array left to allocate
  } errorT;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayIdT;
  typedef logic [`HEAP_INDEX_BITS-1:0] indexT;
  typedef logic [`HEAP_INDEX_BITS:0]   sizeT;       // Holds 0 up to full length
  typedef logic [`HEAP_DATA_BITS-1:0]  dataT;

endpackage

//--- src/heapBuses.sv
// Heap internal buses
// Controller links to the allocator, the element store and the ALU

`timescale 1ns/10ps

interface allocBus;
  logic             allocate;                       // Strobe, take newArray
  logic             releaseArray;                   // Strobe, free arrayId
  heapPkg::arrayIdT arrayId;                        // Array under request
  heapPkg::arrayIdT newArray;                       // Next array to hand out
  logic             canAllocate;                    // A free array exists
  heapPkg::errorT   status;                         // Allocation state of arrayId

  modport controller (output allocate, releaseArray, arrayId,
                      input  newArray, canAllocate, status);
  modport target     (input  allocate, releaseArray, arrayId,
                      output newArray, canAllocate, status);
endinterface

interface storeBus;
  heapPkg::arrayIdT arrayId;
  heapPkg::indexT   index;
  heapPkg::dataT    writeData;
  logic             writeEnable;                    // Element write at the edge
  logic             sizeWrite;                      // Size update at the edge
  heapPkg::sizeT    newSize;
  logic             clearSize;                      // Empty the array on allocation
  heapPkg::dataT    readData;                       // Element at index
  heapPkg::dataT    topData;                        // Element at size minus one
  heapPkg::sizeT    size;

  modport controller (output arrayId, index, writeData, writeEnable, sizeWrite, newSize,
                             clearSize,
                      input  readData, topData, size);
  modport target     (input  arrayId, index, writeData, writeEnable, sizeWrite, newSize,
                             clearSize,
                      output readData, topData, size);
endinterface

interface aluBus;
  heapPkg::opcodeT opcode;
  heapPkg::dataT   element;                         // Current stored value
  heapPkg::dataT   dataIn;                          // Request operand
  heapPkg::dataT   newValue;                        // Value to store back
  heapPkg::dataT   returnValue;                     // Value for the response

  modport controller (output opcode, element, dataIn, input newValue, returnValue);
  modport target     (input opcode, element, dataIn, output newValue, returnValue);
endinterface

//--- src/heapControl.sv
// Heap controller
// Decodes a request, checks it, steers the datapath strobes and
// registers the one-cycle response

`timescale 1ns/10ps
`include "heap_defines.svh"

module heapControl (
  input  logic             clock,
  input  logic             reset,
  input  logic             valid,                   // Request strobe
  input  heapPkg::opcodeT  opcode,
  input  heapPkg::arrayIdT arrayId,
  input  heapPkg::indexT   index,
  input  heapPkg::dataT    dataIn,
  output logic             done,                    // Response pulse
  output heapPkg::dataT    dataOut,
  output heapPkg::errorT   errorCode,
  allocBus.controller      alloc,
  storeBus.controller      store,
  aluBus.controller        alu
);

  logic           isElementOp;                      // Read-modify-write request
  logic           accept;                           // Valid and error free
  heapPkg::sizeT  size;                             // Size of addressed array
  heapPkg::sizeT  indexWide;                        // Index widened for compares
  heapPkg::errorT error;
  heapPkg::dataT  result;                           // Response data before the register

  // ------------------------------------------------------------
  // Datapath steering
  // ------------------------------------------------------------
  assign isElementOp = opcode inside {heapPkg::opAdd, heapPkg::opAddAfter, heapPkg::opSub,
                                      heapPkg::opSubAfter, heapPkg::opAnd, heapPkg::opOr,
                                      heapPkg::opXor, heapPkg::opNot};
  assign size      = store.size;
  assign indexWide = {1'b0, index};

  assign alloc.arrayId   = arrayId;
  assign store.arrayId   = (opcode == heapPkg::opAlloc) ? alloc.newArray : arrayId;
  assign store.index     = (opcode == heapPkg::opPush) ? size[`HEAP_INDEX_BITS-1:0] : index;
  assign store.writeData = isElementOp ? alu.newValue : dataIn;

  assign alu.opcode  = opcode;
  assign alu.element = store.readData;              // Old value at index
  assign alu.dataIn  = dataIn;

  // ------------------------------------------------------------
  // Error checks
  // ------------------------------------------------------------
  always_comb begin
    error = heapPkg::errNone;
    if (opcode == heapPkg::opAlloc) begin
      if (!alloc.canAllocate) error = heapPkg::errNoMemory;
    end else if (alloc.status != heapPkg::errNone) begin
      error = alloc.status;                         // Not allocated or freed
    end else if (opcode == heapPkg::opRead || isElementOp) begin
      if (indexWide >= size) error = heapPkg::errOutOfBounds;
    end else if (opcode == heapPkg::opPush) begin
      if (size == `HEAP_ARRAY_LENGTH) error = heapPkg::errFull;
    end else if (opcode == heapPkg::opPop) begin
      if (size == '0) error = heapPkg::errEmpty;
    end
  end

  assign accept = valid && (error == heapPkg::errNone);

  // ------------------------------------------------------------
  // Strobes and response data
  // ------------------------------------------------------------
  always_comb begin
    alloc.allocate     = 1'b0;
    alloc.releaseArray = 1'b0;
    store.writeEnable  = 1'b0;
    store.sizeWrite    = 1'b0;
    store.clearSize    = 1'b0;
    store.newSize      = size;
    result             = '0;                        // Errors return zero
    if (accept) begin
      case (opcode)
        heapPkg::opWrite: begin
          store.writeEnable = 1'b1;
          if (indexWide >= size) begin              // Grow to cover index
            store.sizeWrite = 1'b1;
            store.newSize   = indexWide + 1'b1;
          end
          result = dataIn;
        end
        heapPkg::opRead: result = store.readData;
        heapPkg::opSize: result = heapPkg::dataT'(size);
        heapPkg::opPush: begin
          store.writeEnable = 1'b1;                 // Lands at index size
          store.sizeWrite   = 1'b1;
          store.newSize     = size + 1'b1;
          result            = dataIn;               // Echo the pushed value
        end
        heapPkg::opPop: begin
          store.sizeWrite = 1'b1;
          store.newSize   = size - 1'b1;
          result          = store.topData;
        end
        heapPkg::opAlloc: begin
          alloc.allocate  = 1'b1;
          store.clearSize = 1'b1;                   // Fresh array starts empty
          result          = heapPkg::dataT'(alloc.newArray);
        end
        heapPkg::opFree: alloc.releaseArray = 1'b1;
        default: begin
          if (isElementOp) begin
            store.writeEnable = 1'b1;               // Store the ALU value
            result            = alu.returnValue;
          end
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // Response register
  // ------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      done      <= 1'b0;
      dataOut   <= '0;
      errorCode <= heapPkg::errNone;
    end else begin
      done <= valid;                                // One cycle after the request
      if (valid) begin                              // Hold until the next response
        dataOut   <= result;
        errorCode <= error;
      end
    end
  end

endmodule

//--- src/arrayAllocator.sv
// Array allocator
// High-water count of arrays handed out, per-array allocation flags and
// a LIFO stack of freed array numbers

`timescale 1ns/10ps
`include "heap_defines.svh"

module arrayAllocator (
  input logic     clock,
  input logic     reset,
  allocBus.target bus
);

  heapPkg::arrayIdT            freeStack [`HEAP_ARRAYS];   // Freed array numbers
  logic [`HEAP_ARRAY_BITS:0]   stackCount;                 // Entries on the stack
  logic [`HEAP_ARRAY_BITS:0]   highWater;                  // Arrays ever handed out
  logic [`HEAP_ARRAYS-1:0]     allocated;                  // One flag per array
  logic                        stackEmpty;
  heapPkg::arrayIdT            pushSlot;                   // Next free stack slot
  heapPkg::arrayIdT            topSlot;                    // Slot of the top entry

  assign stackEmpty = (stackCount == '0);
  assign pushSlot   = stackCount[`HEAP_ARRAY_BITS-1:0];
  assign topSlot    = pushSlot - 1'b1;              // Wraps to last slot when full

  // Reuse freed arrays first, newest first
  assign bus.newArray    = stackEmpty ? highWater[`HEAP_ARRAY_BITS-1:0] : freeStack[topSlot];
  assign bus.canAllocate = !(stackEmpty && highWater == `HEAP_ARRAYS);

  always_comb begin
    if ({1'b0, bus.arrayId} >= highWater) bus.status = heapPkg::errNotAllocated;
    else if (!allocated[bus.arrayId])     bus.status = heapPkg::errFreed;
    else                                  bus.status = heapPkg::errNone;
  end

  // ------------------------------------------------------------
  // Counters and flags
  // ------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      stackCount <= '0;
      highWater  <= '0;
      allocated  <= '0;
    end else if (bus.allocate) begin
      allocated[bus.newArray] <= 1'b1;
      if (stackEmpty) highWater  <= highWater + 1'b1;   // Brand new array
      else            stackCount <= stackCount - 1'b1;  // Pop a freed one
    end else if (bus.releaseArray) begin
      allocated[bus.arrayId] <= 1'b0;
      stackCount             <= stackCount + 1'b1;
    end
  end

  // Stack contents
  always_ff @(posedge clock) begin
    if (bus.releaseArray) freeStack[pushSlot] <= bus.arrayId;
  end

endmodule

//--- src/arrayStore.sv
// Array element store
// Element memory for every array plus the per-array size table,
// combinational reads and edge writes

`timescale 1ns/10ps
`include "heap_defines.svh"

module arrayStore (
  input logic     clock,
  input logic     reset,
  storeBus.target bus
);

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------
  heapPkg::dataT elements [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];  // Fixed block per array
  heapPkg::sizeT sizes    [`HEAP_ARRAYS];                      // Live element count
  heapPkg::sizeT currentSize;                                  // Size of addressed array
  heapPkg::indexT topIndex;                                    // Last live element

  // ------------------------------------------------------------
  // Combinational reads
  // ------------------------------------------------------------
  assign currentSize = sizes[bus.arrayId];
  assign topIndex    = currentSize[`HEAP_INDEX_BITS-1:0] - 1'b1;  // Only used when size > 0

  assign bus.size     = currentSize;
  assign bus.readData = elements[bus.arrayId][bus.index];
  assign bus.topData  = elements[bus.arrayId][topIndex];

  // ------------------------------------------------------------
  // Element writes
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (bus.writeEnable) begin
      elements[bus.arrayId][bus.index] <= bus.writeData;
    end
  end

  // ------------------------------------------------------------
  // Size table
  // ------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;                             // Every array starts empty
      end
    end else if (bus.clearSize) begin
      sizes[bus.arrayId] <= '0;                     // Allocation wipes old contents
    end else if (bus.sizeWrite) begin
      sizes[bus.arrayId] <= bus.newSize;
    end
  end

endmodule

//--- src/elementAlu.sv
// Element ALU
// New stored value and response value for the read-modify-write operations

`timescale 1ns/10ps

module elementAlu (
  aluBus.target bus
);

  heapPkg::dataT result;                            // Value written back
  logic          returnsOld;                        // Response carries old value

  // Arithmetic wraps at the element width
  always_comb begin
    case (bus.opcode)
      heapPkg::opAdd,
      heapPkg::opAddAfter: result = bus.element + bus.dataIn;
      heapPkg::opSub,
      heapPkg::opSubAfter: result = bus.element - bus.dataIn;
      heapPkg::opAnd:      result = bus.element & bus.dataIn;
      heapPkg::opOr:       result = bus.element | bus.dataIn;
      heapPkg::opXor:      result = bus.element ^ bus.dataIn;
      heapPkg::opNot:      result = ~bus.element;   // Operand ignored
      default:             result = bus.element;    // Non-ALU request, leave as is
    endcase
  end

  assign returnsOld = (bus.opcode == heapPkg::opAddAfter) ||
                      (bus.opcode == heapPkg::opSubAfter);

  assign bus.newValue    = result;
  assign bus.returnValue = returnsOld ? bus.element : result;

endmodule

//--- src/heapMemory.sv
// Heap memory top level
// Controller, allocator, element store and ALU joined by the internal buses

`timescale 1ns/10ps

module heapMemory (
  input  logic             clock,
  input  logic             reset,                   // Active low, asynchronous
  input  logic             valid,                   // One-cycle request strobe
  input  heapPkg::opcodeT  opcode,
  input  heapPkg::arrayIdT arrayId,
  input  heapPkg::indexT   index,
  input  heapPkg::dataT    dataIn,
  output logic             done,                    // Pulse one cycle after valid
  output heapPkg::dataT    dataOut,
  output heapPkg::errorT   errorCode
);

  // ------------------------------------------------------------
  // Internal buses
  // ------------------------------------------------------------
  allocBus allocIf ();
  storeBus storeIf ();
  aluBus   aluIf ();

  // ------------------------------------------------------------
  // Blocks
  // ------------------------------------------------------------
  heapControl control (
    .clock     (clock),
    .reset     (reset),
    .valid     (valid),
    .opcode    (opcode),
    .arrayId   (arrayId),
    .index     (index),
    .dataIn    (dataIn),
    .done      (done),
    .dataOut   (dataOut),
    .errorCode (errorCode),
    .alloc     (allocIf.controller),
    .store     (storeIf.controller),
    .alu       (aluIf.controller)
  );

  arrayAllocator allocator (
    .clock (clock),
    .reset (reset),
    .bus   (allocIf.target)
  );

  arrayStore store (
    .clock (clock),
    .reset (reset),
    .bus   (storeIf.target)
  );

  elementAlu alu (
    .bus (aluIf.target)
  );

endmodule

//--- tests/clockGen.sv
// Testbench clock and reset
// 40 ns clock, active-low reset held for the first 8 cycles

`timescale 1ns/10ps

module clockGen (
  output logic clock,
  output logic reset
);

  localparam time halfPeriod  = 20ns;
  localparam int  resetCycles = 8;

  initial begin
    clock = 1'b0;
    forever #(halfPeriod) clock = ~clock;
  end

  initial begin
    reset = 1'b0;                                   // Asserted from time zero
    repeat (resetCycles) @(posedge clock);
    #2 reset = 1'b1;                                // Released clear of the edge
  end

endmodule

//--- tests/heapMemoryTb.sv
// Heap memory testbench
// Replays the request trace, checks each response value, error code
// and the one-cycle response latency

`timescale 1ns/10ps

module heapMemoryTb;

  localparam string traceFile = "tests/heap_trace.txt";

  typedef struct packed {
    logic [4:0]       op;
    heapPkg::arrayIdT arrayId;
    heapPkg::indexT   index;
    heapPkg::dataT    dataIn;
    heapPkg::dataT    expData;                      // Expected dataOut
    logic [2:0]       expError;                     // Expected errorCode
  } requestT;

  logic             clock;
  logic             reset;
  logic             valid;
  heapPkg::opcodeT  opcode;
  heapPkg::arrayIdT arrayId;
  heapPkg::indexT   index;
  heapPkg::dataT    dataIn;
  logic             done;
  heapPkg::dataT    dataOut;
  heapPkg::errorT   errorCode;

  requestT trace [$];                               // All requests from the file
  int      cycleCount   = 0;
  int      timeoutLimit = 0;                        // Set once the trace is loaded
  int      waited;

  clockGen clocks (
    .clock (clock),
    .reset (reset)
  );

  heapMemory DUT (
    .clock     (clock),
    .reset     (reset),
    .valid     (valid),
    .opcode    (opcode),
    .arrayId   (arrayId),
    .index     (index),
    .dataIn    (dataIn),
    .done      (done),
    .dataOut   (dataOut),
    .errorCode (errorCode)
  );

  // ------------------------------------------------------------
  // Failure reporting and value checks
  // ------------------------------------------------------------
  task automatic reportFailure(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string name, input logic [15:0] actual,
                            input logic [15:0] expected);
    if (actual !== expected) begin                  // X counts as wrong
      reportFailure($sformatf("mismatch at %0t: %s got %h expected %h",
                              $time, name, actual, expected));
    end
  endtask

  // ------------------------------------------------------------
  // Trace loading
  // ------------------------------------------------------------
  task automatic loadTrace;
    int         fd;
    int         fields;
    string      line;
    requestT    req;
    logic [4:0] op;
    logic [2:0] arr;
    logic [2:0] idx;
    logic [15:0] din;
    logic [15:0] dout;
    logic [2:0] err;
    fd = $fopen(traceFile, "r");
    if (fd == 0) reportFailure("could not open the trace file");
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) break;
      if (line.len() > 0 && line.getc(0) != "#") begin     // Skip comment lines
        fields = $sscanf(line, "%h %h %h %h %h %h", op, arr, idx, din, dout, err);
        if (fields == 6) begin
          req.op       = op;
          req.arrayId  = arr;
          req.index    = idx;
          req.dataIn   = din;
          req.expData  = dout;
          req.expError = err;
          trace.push_back(req);
        end else if (fields > 0) begin
          reportFailure($sformatf("trace line has %0d fields instead of 6", fields));
        end
      end
    end
    $fclose(fd);
    if (trace.size() == 0) reportFailure("the trace file holds no requests");
    timeoutLimit = trace.size() * 4 + 20;           // Reset and drain fit in the margin
  endtask

  // ------------------------------------------------------------
  // Timeout
  // ------------------------------------------------------------
  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (timeoutLimit != 0 && cycleCount >= timeoutLimit) begin
      reportFailure($sformatf("timeout after %0d cycles, trace did not finish", cycleCount));
    end
  end

  // ------------------------------------------------------------
  // Request driving and response waiting
  // ------------------------------------------------------------
  task automatic driveRequest(input requestT req);
    valid   = 1'b1;
    opcode  = heapPkg::opcodeT'(req.op);
    arrayId = req.arrayId;
    index   = req.index;
    dataIn  = req.dataIn;
  endtask

  task automatic awaitDone(output int cycles);
    cycles = 0;
    do begin
      @(posedge clock);
      #1;                                           // Sample after the edge settles
      cycles++;
    end while (!done);
  endtask

  initial begin
    valid   = 1'b0;
    opcode  = heapPkg::opRead;
    arrayId = '0;
    index   = '0;
    dataIn  = '0;
    loadTrace();
    @(posedge reset);
    @(posedge clock);
    #2;                                             // Drive point after the edge
    // Idle response state out of reset
    checkValue("done after reset", 16'(done), 16'd0);
    checkValue("dataOut after reset", dataOut, 16'h0000);
    checkValue("errorCode after reset", 16'(errorCode), 16'(heapPkg::errNone));
    for (int n = 0; n < trace.size(); n++) begin
      driveRequest(trace[n]);
      awaitDone(waited);
      checkValue($sformatf("done latency (line %0d)", n), 16'(waited), 16'd1);
      checkValue($sformatf("dataOut (line %0d)", n), dataOut, trace[n].expData);
      checkValue($sformatf("errorCode (line %0d)", n), 16'(errorCode), 16'(trace[n].expError));
      #1;                                           // Next request back to back
    end
    valid = 1'b0;
    @(posedge clock);
    #1;
    checkValue("done after last request", 16'(done), 16'd0);   // Single-cycle pulse
    $display("TEST OK");
    $finish;
  end

endmodule

//--- tb.f
+incdir+src
src/heapPkg.sv
src/heapBuses.sv
src/heapControl.sv
src/arrayAllocator.sv
src/arrayStore.sv
src/elementAlu.sv
src/heapMemory.sv
tests/clockGen.sv
tests/heapMemoryTb.sv

//--- tests/heap_trace.txt
# Heap request trace, all fields hex, one request per line
# opcode arrayId index dataIn expectedDataOut expectedErrorCode
03 0 0 0000 0000 1
12 0 0 0000 0000 0
12 0 0 0000 0001 0
12 0 0 0000 0002 0
02 0 2 1234 1234 0
04 0 0 0000 0003 0
03 0 2 0000 1234 0
03 0 3 0000 0000 3
02 0 0 abcd abcd 0
02 1 4 5555 5555 0
04 1 0 0000 0005 0
13 1 0 0000 0000 0
13 2 0 0000 0000 0
03 1 0 0000 0000 2
02 2 1 7777 0000 2
12 0 0 0000 0002 0
12 0 0 0000 0001 0
04 1 0 0000 0000 0
0f 2 0 0000 0000 5
0e 2 0 0011 0011 0
0e 2 0 0012 0012 0
0e 2 0 0013 0013 0
0e 2 0 0014 0014 0
0e 2 0 0015 0015 0
0e 2 0 0016 0016 0
0e 2 0 0017 0017 0
0e 2 0 0018 0018 0
0e 2 0 0019 0000 4
0f 2 0 0000 0018 0
0f 2 0 0000 0017 0
04 2 0 0000 0006 0
14 0 2 0010 1244 0
15 0 2 fff0 1244 0
03 0 2 0000 1234 0
16 0 0 0001 abcc 0
17 0 0 abcd abcc 0
03 0 0 0000 ffff 0
1e 0 0 0f0f 0f0f 0
1c 0 0 3000 3f0f 0
1d 0 0 ffff c0f0 0
1b 0 0 1234 3f0f 0
03 0 0 0000 3f0f 0
14 0 3 0001 0000 3
04 0 0 0000 0003 0
12 0 0 0000 0003 0
12 0 0 0000 0004 0
12 0 0 0000 0005 0
12 0 0 0000 0006 0
12 0 0 0000 0007 0
12 0 0 0000 0000 6
